//--- design/vga_pkg.sv
`default_nettype none

package vga_pkg;

    // horizontal timing, blank comes first in each line
    localparam int h_front = 16;
    localparam int h_pulse = 96;
    localparam int h_back = 48;
    localparam int h_visible = 640;
    localparam int h_blank = h_front + h_pulse + h_back;
    localparam int h_total = h_blank + h_visible;

    // vertical timing, visible lines come first in each frame
    localparam int v_visible = 400;
    localparam int v_front = 12;
    localparam int v_pulse = 2;
    localparam int v_back = 35;
    localparam int v_total = v_visible + v_front + v_pulse + v_back;

    localparam int text_cols = 40;
    localparam int text_rows = 25;

    typedef logic [9:0] col_t;
    typedef logic [8:0] row_t;
    // r1 r0 g1 g0 b1 b0
    typedef logic [5:0] rgb_t;
    typedef logic [7:0] char_t;
    typedef logic [7:0] attr_t;
    typedef logic [9:0] text_addr_t;
    typedef logic [10:0] font_addr_t;

    // standard 16-colour EGA palette
    function automatic rgb_t ega_rgb(input logic [3:0] idx);
        rgb_t c;
        case (idx)
            4'd0: c = 6'b000000;
            4'd1: c = 6'b000010;
            4'd2: c = 6'b001000;
            4'd3: c = 6'b001010;
            4'd4: c = 6'b100000;
            4'd5: c = 6'b100010;
            4'd6: c = 6'b100100;
            4'd7: c = 6'b101010;
            4'd8: c = 6'b010101;
            4'd9: c = 6'b010111;
            4'd10: c = 6'b011101;
            4'd11: c = 6'b011111;
            4'd12: c = 6'b110101;
            4'd13: c = 6'b110111;
            4'd14: c = 6'b111101;
            default: c = 6'b111111;
        endcase
        return c;
    endfunction

endpackage

`default_nettype wire

//--- design/bus_pkg.sv
`default_nettype none

package bus_pkg;

    typedef logic [12:0] bus_addr_t;
    typedef logic [7:0] bus_data_t;

    // address map
    localparam bus_addr_t text_last = 13'h03FF;
    localparam bus_addr_t attr_base = 13'h0800;
    localparam bus_addr_t attr_last = 13'h0BFF;
    localparam bus_addr_t font_base = 13'h1000;
    localparam bus_addr_t font_last = 13'h17FF;
    localparam bus_addr_t line_lo_addr = 13'h1800;
    localparam bus_addr_t line_hi_addr = 13'h1801;

    // true for addresses backed by one of the display memories
    function automatic logic is_mem_addr(input bus_addr_t a);
        return (a <= text_last) || (a >= attr_base && a <= attr_last) ||
               (a >= font_base && a <= font_last);
    endfunction

endpackage

`default_nettype wire

//--- design/video_mem_if.sv
`default_nettype none

interface video_mem_if import vga_pkg::*; ();

    text_addr_t text_addr;
    font_addr_t font_addr;
    // all read data arrives one cycle after its address
    char_t char_code;
    attr_t attr;
    logic [7:0] font_byte;

    modport renderer (
        output text_addr, font_addr,
        input char_code, attr, font_byte
    );

    modport memory (
        input text_addr, font_addr,
        output char_code, attr, font_byte
    );

endinterface

`default_nettype wire

//--- design/raster_timing.sv
`default_nettype none

module raster_timing import vga_pkg::*; (
    input wire CLK_I,
    input wire reset,
    output col_t col,
    output row_t row,
    output logic visible,
    output logic new_line,
    output logic new_frame,
    output logic hsync,
    output logic vsync
);

    logic col_wrap;
    logic row_wrap;

    assign col_wrap = (col == col_t'(h_total - 1));
    assign row_wrap = (row == row_t'(v_total - 1));

    // column and line counters
    always_ff @(posedge CLK_I) begin
        if (reset) begin
            col <= '0;
            row <= '0;
        end else if (col_wrap) begin
            col <= '0;
            if (row_wrap) begin
                row <= '0;
            end else begin
                row <= row + row_t'(1);
            end
        end else begin
            col <= col + col_t'(1);
        end
    end

    // sync pulses are active low and lag the counters by one cycle
    always_ff @(posedge CLK_I) begin
        if (reset) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            hsync <= !(col >= h_front && col < h_front + h_pulse);
            vsync <= !(row >= v_visible + v_front && row < v_visible + v_front + v_pulse);
        end
    end

    assign visible = (col >= h_blank) && (row < v_visible);
    // start of line falls in the blank, so the renderer has time to move its base
    assign new_line = (col == '0);
    assign new_frame = new_line && (row == '0);

    // hsync may only be low while the live column is one step past the pulse window
    assert property (@(posedge CLK_I) disable iff (reset)
        !hsync |-> (col > h_front && col <= h_front + h_pulse));

endmodule

`default_nettype wire

//--- design/text_memory.sv
`default_nettype none

module text_memory import vga_pkg::*, bus_pkg::*; (
    input wire CLK_I,
    input wire mem_we,
    input wire bus_addr_t mem_addr,
    input wire bus_data_t mem_wdata,
    video_mem_if.memory vmem
);

    char_t text_ram [0:1023];
    attr_t attr_ram [0:1023];
    logic [7:0] font_ram [0:2047];

    logic text_we;
    logic attr_we;
    logic font_we;

    // region decode, the bus port only forwards mapped addresses
    assign text_we = mem_we && (mem_addr <= text_last);
    assign attr_we = mem_we && (mem_addr >= attr_base) && (mem_addr <= attr_last);
    assign font_we = mem_we && (mem_addr >= font_base) && (mem_addr <= font_last);

    always_ff @(posedge CLK_I) begin
        if (text_we) begin
            text_ram[mem_addr[9:0]] <= mem_wdata;
        end
        vmem.char_code <= text_ram[vmem.text_addr];
    end

    always_ff @(posedge CLK_I) begin
        if (attr_we) begin
            attr_ram[mem_addr[9:0]] <= mem_wdata;
        end
        vmem.attr <= attr_ram[vmem.text_addr];
    end

    // eight bytes per glyph, top line first
    always_ff @(posedge CLK_I) begin
        if (font_we) begin
            font_ram[mem_addr[10:0]] <= mem_wdata;
        end
        vmem.font_byte <= font_ram[vmem.font_addr];
    end

    // the status port must filter out writes to unmapped space
    assert property (@(posedge CLK_I) mem_we |-> is_mem_addr(mem_addr));

endmodule

`default_nettype wire

//--- design/char_renderer.sv
`default_nettype none

module char_renderer import vga_pkg::*; (
    input wire CLK_I,
    input wire reset,
    input wire col_t col,
    input wire row_t row,
    input wire visible,
    input wire new_line,
    input wire new_frame,
    video_mem_if.renderer vmem,
    output rgb_t rgb
);

    text_addr_t line_base;
    col_t px;

    // stage 1, waiting for character and attribute
    logic [2:0] row_sub1;
    logic [2:0] col_sub1;
    logic vis1;

    // stage 2, waiting for the font byte
    logic [2:0] col_sub2;
    logic vis2;
    attr_t attr2;

    logic glyph_bit;

    // first cell of the current character row
    always_ff @(posedge CLK_I) begin
        if (reset || new_frame) begin
            line_base <= '0;
        end else if (new_line && row[3:0] == 4'd0 && row[8:4] < text_rows) begin
            line_base <= line_base + text_addr_t'(text_cols);
        end
    end

    // screen x, only meaningful inside the visible window
    assign px = col - col_t'(h_blank);
    assign vmem.text_addr = line_base + text_addr_t'(px[9:4]);
    // row is delayed so the glyph line stays with its cell across a line wrap
    assign vmem.font_addr = {vmem.char_code, row_sub1};

    always_ff @(posedge CLK_I) begin
        row_sub1 <= row[3:1];
        col_sub1 <= col[3:1];
        col_sub2 <= col_sub1;
        attr2 <= vmem.attr;
    end

    always_ff @(posedge CLK_I) begin
        if (reset) begin
            vis1 <= 1'b0;
            vis2 <= 1'b0;
        end else begin
            vis1 <= visible;
            vis2 <= vis1;
        end
    end

    // leftmost font pixel is the msb
    assign glyph_bit = vmem.font_byte[3'd7 - col_sub2];

    always_ff @(posedge CLK_I) begin
        if (reset || !vis2) begin
            rgb <= '0;
        end else if (glyph_bit) begin
            rgb <= ega_rgb(attr2[7:4]);
        end else begin
            rgb <= ega_rgb(attr2[3:0]);
        end
    end

endmodule

`default_nettype wire

//--- design/wb_status_port.sv
`default_nettype none

module wb_status_port import vga_pkg::*, bus_pkg::*; (
    input wire CLK_I,
    input wire reset,
    input wire bus_addr_t adr,
    input wire bus_data_t wdat,
    input wire stb,
    input wire we,
    output logic ack,
    output bus_data_t rdat,
    input wire row_t row,
    output logic mem_we,
    output bus_addr_t mem_addr,
    output bus_data_t mem_wdata
);

    // row msb captured by the low byte read
    logic line_hi;

    // writes reach the memories one cycle after the strobe
    always_ff @(posedge CLK_I) begin
        if (reset) begin
            mem_we <= 1'b0;
        end else begin
            mem_we <= stb && we && is_mem_addr(adr);
        end
    end

    always_ff @(posedge CLK_I) begin
        mem_addr <= adr;
        mem_wdata <= wdat;
    end

    always_ff @(posedge CLK_I) begin
        if (reset) begin
            ack <= 1'b0;
            rdat <= '0;
            line_hi <= 1'b0;
        end else begin
            // always ready, one ack per strobe cycle
            ack <= stb;
            if (stb && !we) begin
                case (adr)
                    line_lo_addr: begin
                        rdat <= row[7:0];
                        line_hi <= row[8];
                    end
                    line_hi_addr: rdat <= {7'b0, line_hi};
                    // screen memory is write only
                    default: rdat <= '0;
                endcase
            end
        end
    end

    assert property (@(posedge CLK_I) disable iff (reset) ack |-> $past(stb));

endmodule

`default_nettype wire

//--- design/vga_text_top.sv
`default_nettype none

module vga_text_top import vga_pkg::*, bus_pkg::*; (
    input wire CLK_I,
    input wire reset,
    input wire bus_addr_t adr,
    input wire bus_data_t wdat,
    input wire stb,
    input wire we,
    output wire ack,
    output wire bus_data_t rdat,
    output wire hsync,
    output wire vsync,
    output wire rgb_t rgb
);

    col_t col;
    row_t row;
    logic visible;
    logic new_line;
    logic new_frame;

    logic mem_we;
    bus_addr_t mem_addr;
    bus_data_t mem_wdata;

    video_mem_if vmem0 ();

    raster_timing timing0 (
        .CLK_I(CLK_I),
        .reset(reset),
        .col(col),
        .row(row),
        .visible(visible),
        .new_line(new_line),
        .new_frame(new_frame),
        .hsync(hsync),
        .vsync(vsync)
    );

    wb_status_port bus0 (
        .CLK_I(CLK_I),
        .reset(reset),
        .adr(adr),
        .wdat(wdat),
        .stb(stb),
        .we(we),
        .ack(ack),
        .rdat(rdat),
        .row(row),
        .mem_we(mem_we),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata)
    );

    text_memory mem0 (
        .CLK_I(CLK_I),
        .mem_we(mem_we),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .vmem(vmem0.memory)
    );

    char_renderer render0 (
        .CLK_I(CLK_I),
        .reset(reset),
        .col(col),
        .row(row),
        .visible(visible),
        .new_line(new_line),
        .new_frame(new_frame),
        .vmem(vmem0.renderer),
        .rgb(rgb)
    );

endmodule

`default_nettype wire

//--- verification/vga_text_tb.sv
`default_nettype none

module vga_text_tb import vga_pkg::*, bus_pkg::*; ();

    // three frames leave ample room for stimulus that spans just over one
    localparam int cycle_limit = 3 * h_total * v_total + 2000;

    logic CLK_I;
    logic reset;
    bus_addr_t adr;
    bus_data_t wdat;
    logic stb;
    logic we;
    wire ack;
    wire bus_data_t rdat;
    wire hsync;
    wire vsync;
    wire rgb_t rgb;

    // reference raster position of the current cycle
    int m_col = 0;
    int m_row = 0;
    int m_prev_row = 0;
    logic stb_q;
    int cycles = 0;

    vga_text_top dut0 (
        .CLK_I(CLK_I),
        .reset(reset),
        .adr(adr),
        .wdat(wdat),
        .stb(stb),
        .we(we),
        .ack(ack),
        .rdat(rdat),
        .hsync(hsync),
        .vsync(vsync),
        .rgb(rgb)
    );

    initial begin
        CLK_I = 1'b0;
        forever #4 CLK_I = ~CLK_I;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    // sync pulses show up one cycle after the counters enter the window
    function automatic logic expected_hsync(input int c);
        return !(c >= h_front + 1 && c <= h_front + h_pulse);
    endfunction

    function automatic logic expected_vsync(input int prev_row);
        return !(prev_row >= v_visible + v_front && prev_row < v_visible + v_front + v_pulse);
    endfunction

    always @(posedge CLK_I) begin
        if (reset) begin
            m_col <= 0;
            m_row <= 0;
            m_prev_row <= 0;
            stb_q <= 1'b0;
        end else begin
            m_prev_row <= m_row;
            stb_q <= stb;
            if (m_col == h_total - 1) begin
                m_col <= 0;
                m_row <= (m_row == v_total - 1) ? 0 : m_row + 1;
            end else begin
                m_col <= m_col + 1;
            end
        end
    end

    always @(posedge CLK_I) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            stop_run($sformatf("Timeout: the stimulus did not finish within %0d cycles",
                               cycle_limit));
        end
    end

    // handshake and sync checks on every cycle
    always @(negedge CLK_I) begin
        if (!reset) begin
            assert (ack === stb_q) else report_mismatch("ack", ack, stb_q);
            assert (hsync === expected_hsync(m_col))
                else report_mismatch("hsync", hsync, expected_hsync(m_col));
            assert (vsync === expected_vsync(m_prev_row))
                else report_mismatch("vsync", vsync, expected_vsync(m_prev_row));
        end
    end

    task automatic wait_for_position(input int c, input int r);
        while (!(m_col == c && m_row == r)) begin
            @(negedge CLK_I);
        end
    endtask

    task automatic bus_write(input int a, input int d);
        adr = bus_addr_t'(a);
        wdat = bus_data_t'(d);
        we = 1'b1;
        stb = 1'b1;
        @(negedge CLK_I);
        stb = 1'b0;
        we = 1'b0;
        @(negedge CLK_I);
    endtask

    // low byte is sampled at (c, r) and the high byte in the next cycle
    task automatic status_read(input int c, input int r, input int lo, input int hi);
        logic [8:0] row_at_lo;
        wait_for_position(c, r);
        row_at_lo = 9'(m_row);
        assert (lo[7:0] == row_at_lo[7:0] && hi[7:0] == {7'b0, row_at_lo[8]})
            else stop_run("Stimulus file expects a status line the reference model never sees");
        adr = line_lo_addr;
        we = 1'b0;
        stb = 1'b1;
        @(negedge CLK_I);
        assert (rdat === lo[7:0]) else report_mismatch("rdat", rdat, lo);
        adr = line_hi_addr;
        @(negedge CLK_I);
        assert (rdat === hi[7:0]) else report_mismatch("rdat", rdat, hi);
        stb = 1'b0;
        @(negedge CLK_I);
    endtask

    task automatic probe_pixel(input int x, input int y, input int exp);
        wait_for_position(x + h_blank, y);
        repeat (3) @(negedge CLK_I);
        assert (rgb === exp[5:0]) else report_mismatch("rgb", rgb, exp);
    endtask

    initial begin
        int fd;
        int code;
        int op;
        int a;
        int b;
        int c;
        int d;
        int records;
        logic [8*160-1:0] skip;
        records = 0;
        reset = 1'b1;
        adr = '0;
        wdat = '0;
        stb = 1'b0;
        we = 1'b0;
        repeat (4) @(posedge CLK_I);
        @(negedge CLK_I);
        reset = 1'b0;
        assert (rdat === 8'h00) else report_mismatch("rdat", rdat, 0);
        assert (rgb === 6'h00) else report_mismatch("rgb", rgb, 0);
        fd = $fopen("verification/vga_text_stimulus.txt", "r");
        if (fd == 0) begin
            stop_run("Cannot open verification/vga_text_stimulus.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%d", op);
            if (code == 1) begin
                case (op)
                    1: begin
                        code = $fscanf(fd, "%h %h", a, b);
                        bus_write(a, b);
                    end
                    2: begin
                        code = $fscanf(fd, "%d %d %h %h", a, b, c, d);
                        status_read(a, b, c, d);
                    end
                    3: begin
                        code = $fscanf(fd, "%d %d %h", a, b, c);
                        probe_pixel(a, b, c);
                    end
                    default: stop_run("Unknown record type in the stimulus file");
                endcase
                records++;
            end else if (code == 0) begin
                // comment line
                code = $fgets(skip, fd);
            end
        end
        $fclose(fd);
        if (records == 0) begin
            stop_run("Stimulus file holds no records");
        end
        repeat (4) @(negedge CLK_I);
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
design/vga_pkg.sv
design/bus_pkg.sv
design/video_mem_if.sv
design/raster_timing.sv
design/text_memory.sv
design/char_renderer.sv
design/wb_status_port.sv
design/vga_text_top.sv
verification/vga_text_tb.sv

//--- verification/vga_text_stimulus.txt
# 1 = bus write: addr data (hex), 2 = status read at raster col row (dec): lo hi (hex)
# 3 = pixel probe at screen x y (dec): rgb (hex), probes in raster order
1 0001 41
1 0801 1E
1 1209 C3
1 002A 42
1 082A 4A
1 1212 81
1 0005 43
1 0805 72
1 1005 FF
1 1218 0F
3 80 0 08
3 94 0 2A
3 17 2 02
3 20 3 3D
3 -100 17 00
3 32 20 20
3 34 21 1D
3 47 21 20
2 799 255 FF 00
2 10 300 2C 01
3 100 420 00
# second frame, line base back at zero
3 17 2 02
